// ==== include/mmcpu_defines.svh ====
`ifndef MMCPU_DEFINES_SVH
`define MMCPU_DEFINES_SVH

// Register, instruction and data word width
`define MMCPU_DATA_WIDTH 8
// Address width on the instruction and data buses
`define MMCPU_ADDR_WIDTH 8

// Opcode sits in the upper nibble, sub-field below it
`define MMCPU_OP_MSB 7
`define MMCPU_OP_LSB 4

`define MMCPU_HALT_OP 4'd15 // Stops fetching

`endif

// ==== logic/mmcpu_pkg.sv ====
`default_nettype none

`include "mmcpu_defines.svh"

package mmcpu_pkg;

    // One state per instruction step, bus states paired with a wait state
    typedef enum logic [4:0] {
        ST_FETCH1, ST_FETCH1W, ST_FETCH2, ST_FETCH3,
        ST_JMP1, ST_NJMP, ST_JMP2,
        ST_OPND1, ST_OPND1W, ST_OPND2, // Operand word from ROM into AR
        ST_RDMEM1, ST_RDMEM1W, ST_RDMEM2, // Data memory into DR
        ST_COPY, ST_LOAD,
        ST_STORE1, ST_STORE2, ST_STORE3, ST_STORE3W,
        ST_ASSIGN, ST_RESET, ST_MOVE, ST_SET, ST_MUL, ST_ADD, ST_INC,
        ST_HALT
    } stateT;

    typedef enum logic [3:0] {
        NOP = 4'd0, JMP = 4'd1, COPY = 4'd2, LOAD = 4'd3,
        STORE = 4'd4, ASSIGN = 4'd5, RESET = 4'd6, MOVE = 4'd7,
        SET = 4'd8, MUL = 4'd9, ADD = 4'd10, INC = 4'd11,
        HALT = `MMCPU_HALT_OP
    } opcodeT;

    typedef enum logic [1:0] {ALU_NONE, ALU_SET, ALU_ADD, ALU_MUL} aluOpT;

    typedef enum logic [1:0] {CMP_M, CMP_K, CMP_N} cmpSelT; // Same order as JMP sub-field

    typedef enum logic [3:0] {
        MEM, INSTR, AR, DR, RP, RT, M1, M2, C1, C2, C3, AC
    } busSrcT;

    typedef enum logic [1:0] {BUS_IDLE, BUS_READ, BUS_WRITE} busOpT;

    typedef struct packed {
        logic pc, ir, ar, dr;
        logic rp, rt, m1, k1;
        logic n1, m2, k2, n2;
        logic c1, c2, c3, ac;
    } regMaskT;

    typedef struct packed {
        regMaskT wrEn;
        regMaskT incEn;
        regMaskT clrEn;
        busSrcT  busSrc;
        cmpSelT  cmpSel;
        aluOpT   aluOp;
    } ctrlT;

    // Master side of a Wishbone classic port
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`MMCPU_ADDR_WIDTH-1:0] adr;
        logic [`MMCPU_DATA_WIDTH-1:0] datW;
    } wbReqT;

    typedef struct packed {
        logic                         ack;
        logic [`MMCPU_DATA_WIDTH-1:0] datR;
    } wbRspT;

endpackage

`default_nettype wire

// ==== logic/mmcpu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_alu (
    input  mmcpu_pkg::ctrlT              ctrl,
    input  logic [`MMCPU_DATA_WIDTH-1:0] busValue,
    input  logic [`MMCPU_DATA_WIDTH-1:0] acc,
    input  logic [`MMCPU_DATA_WIDTH-1:0] cmpA,
    input  logic [`MMCPU_DATA_WIDTH-1:0] cmpB,
    output logic [`MMCPU_DATA_WIDTH-1:0] aluResult,
    output logic                         z
);

    logic [2*`MMCPU_DATA_WIDTH-1:0] product;

    assign product = acc * busValue; // Only the low byte is kept

    always_comb begin
        case (ctrl.aluOp)
            mmcpu_pkg::ALU_SET: aluResult = busValue;
            mmcpu_pkg::ALU_ADD: aluResult = acc + busValue; // Wraps at 8 bits
            mmcpu_pkg::ALU_MUL: aluResult = product[`MMCPU_DATA_WIDTH-1:0];
            default:            aluResult = acc;
        endcase
    end

    // Selected loop pair has met its bound
    assign z = (cmpA == cmpB);

endmodule

`default_nettype wire

// ==== logic/mmcpu_busport.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_busport (
    input  logic                         Clk,
    input  logic                         rst,
    input  mmcpu_pkg::busOpT             op,
    input  logic [`MMCPU_ADDR_WIDTH-1:0] adr,
    input  logic [`MMCPU_DATA_WIDTH-1:0] wrData,
    output mmcpu_pkg::wbReqT             req,
    input  mmcpu_pkg::wbRspT             rsp,
    output logic [`MMCPU_DATA_WIDTH-1:0] rdData,
    output logic                         done
);

    typedef enum logic {PORT_IDLE, PORT_BUSY} portStateT;

    portStateT                    state;
    logic                         weQ;
    logic [`MMCPU_ADDR_WIDTH-1:0] adrQ;
    logic [`MMCPU_DATA_WIDTH-1:0] datQ;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= PORT_IDLE;
            done  <= 1'b0;
            weQ   <= 1'b0;
            adrQ  <= '0;
            datQ  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (op != mmcpu_pkg::BUS_IDLE) begin
                        state <= PORT_BUSY; // Request held steady from here on
                        weQ   <= (op == mmcpu_pkg::BUS_WRITE);
                        adrQ  <= adr;
                        datQ  <= wrData;
                    end
                end
                PORT_BUSY: begin
                    if (rsp.ack) begin
                        state <= PORT_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= PORT_IDLE;
            endcase
        end
    end

    // Read data stays until the next read completes
    always_ff @(posedge Clk) begin
        if (state == PORT_BUSY && rsp.ack && !weQ) begin
            rdData <= rsp.datR;
        end
    end

    assign req.cyc  = (state == PORT_BUSY);
    assign req.stb  = (state == PORT_BUSY);
    assign req.we   = weQ;
    assign req.adr  = adrQ;
    assign req.datW = datQ;

endmodule

`default_nettype wire

// ==== logic/mmcpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_control (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic [`MMCPU_DATA_WIDTH-1:0] ir,
    input  logic                         z,
    input  logic                         instrDone,
    input  logic                         dataDone,
    output mmcpu_pkg::ctrlT              ctrl,
    output mmcpu_pkg::busOpT             instrOp,
    output mmcpu_pkg::busOpT             dataOp,
    output logic                         halted
);

    mmcpu_pkg::stateT  state;
    mmcpu_pkg::stateT  nextState;
    mmcpu_pkg::opcodeT opcode;
    logic [`MMCPU_OP_LSB-1:0] sub;

    assign opcode = mmcpu_pkg::opcodeT'(ir[`MMCPU_OP_MSB:`MMCPU_OP_LSB]);
    assign sub    = ir[`MMCPU_OP_LSB-1:0];
    assign halted = (state == mmcpu_pkg::ST_HALT);

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= mmcpu_pkg::ST_FETCH1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = mmcpu_pkg::ST_FETCH1; // Single-cycle steps return to fetch
        case (state)
            mmcpu_pkg::ST_FETCH1:  nextState = mmcpu_pkg::ST_FETCH1W;
            mmcpu_pkg::ST_FETCH1W: nextState = instrDone ? mmcpu_pkg::ST_FETCH2 : state;
            mmcpu_pkg::ST_FETCH2:  nextState = mmcpu_pkg::ST_FETCH3;
            mmcpu_pkg::ST_FETCH3: begin
                case (opcode)
                    mmcpu_pkg::JMP:    nextState = mmcpu_pkg::ST_JMP1;
                    mmcpu_pkg::COPY:   nextState = mmcpu_pkg::ST_OPND1;
                    mmcpu_pkg::LOAD:   nextState = mmcpu_pkg::ST_LOAD;
                    mmcpu_pkg::STORE:  nextState = mmcpu_pkg::ST_STORE1;
                    mmcpu_pkg::ASSIGN: nextState = mmcpu_pkg::ST_OPND1;
                    mmcpu_pkg::RESET:  nextState = mmcpu_pkg::ST_RESET;
                    mmcpu_pkg::MOVE:   nextState = mmcpu_pkg::ST_MOVE;
                    mmcpu_pkg::SET:    nextState = mmcpu_pkg::ST_SET;
                    mmcpu_pkg::MUL:    nextState = mmcpu_pkg::ST_MUL;
                    mmcpu_pkg::ADD:    nextState = mmcpu_pkg::ST_ADD;
                    mmcpu_pkg::INC:    nextState = mmcpu_pkg::ST_INC;
                    mmcpu_pkg::HALT:   nextState = mmcpu_pkg::ST_HALT;
                    default:           nextState = mmcpu_pkg::ST_FETCH1; // NOP and unused codes
                endcase
            end
            // Equal pair falls through, otherwise take the target word
            mmcpu_pkg::ST_JMP1:   nextState = z ? mmcpu_pkg::ST_NJMP : mmcpu_pkg::ST_OPND1;
            mmcpu_pkg::ST_OPND1:  nextState = mmcpu_pkg::ST_OPND1W;
            mmcpu_pkg::ST_OPND1W: nextState = instrDone ? mmcpu_pkg::ST_OPND2 : state;
            mmcpu_pkg::ST_OPND2: begin
                if (opcode == mmcpu_pkg::JMP) begin
                    nextState = mmcpu_pkg::ST_JMP2;
                end else if (opcode == mmcpu_pkg::COPY) begin
                    nextState = mmcpu_pkg::ST_RDMEM1;
                end else begin
                    nextState = mmcpu_pkg::ST_ASSIGN;
                end
            end
            mmcpu_pkg::ST_LOAD:    nextState = mmcpu_pkg::ST_RDMEM1;
            mmcpu_pkg::ST_RDMEM1:  nextState = mmcpu_pkg::ST_RDMEM1W;
            mmcpu_pkg::ST_RDMEM1W: nextState = dataDone ? mmcpu_pkg::ST_RDMEM2 : state;
            mmcpu_pkg::ST_RDMEM2: begin
                if (opcode == mmcpu_pkg::COPY) begin
                    nextState = mmcpu_pkg::ST_COPY;
                end
            end
            mmcpu_pkg::ST_STORE1:  nextState = mmcpu_pkg::ST_STORE2;
            mmcpu_pkg::ST_STORE2:  nextState = mmcpu_pkg::ST_STORE3;
            mmcpu_pkg::ST_STORE3:  nextState = mmcpu_pkg::ST_STORE3W;
            mmcpu_pkg::ST_STORE3W: nextState = dataDone ? mmcpu_pkg::ST_FETCH1 : state;
            mmcpu_pkg::ST_HALT:    nextState = mmcpu_pkg::ST_HALT;
            default: ;
        endcase
    end

    // Moore outputs, sub-field picks the register inside a step
    always_comb begin
        ctrl    = '0;
        instrOp = mmcpu_pkg::BUS_IDLE;
        dataOp  = mmcpu_pkg::BUS_IDLE;
        case (state)
            mmcpu_pkg::ST_FETCH1, mmcpu_pkg::ST_OPND1: instrOp = mmcpu_pkg::BUS_READ;
            mmcpu_pkg::ST_FETCH2, mmcpu_pkg::ST_OPND2: begin
                ctrl.busSrc    = mmcpu_pkg::INSTR;
                ctrl.wrEn.ir   = (state == mmcpu_pkg::ST_FETCH2);
                ctrl.wrEn.ar   = (state == mmcpu_pkg::ST_OPND2);
                ctrl.incEn.pc  = 1'b1;
            end
            mmcpu_pkg::ST_JMP1: ctrl.cmpSel = mmcpu_pkg::cmpSelT'(sub[1:0]);
            mmcpu_pkg::ST_NJMP: ctrl.incEn.pc = 1'b1; // Step over the target word
            mmcpu_pkg::ST_JMP2: begin
                ctrl.busSrc  = mmcpu_pkg::AR;
                ctrl.wrEn.pc = 1'b1;
            end
            mmcpu_pkg::ST_RDMEM1: dataOp = mmcpu_pkg::BUS_READ;
            mmcpu_pkg::ST_RDMEM2: begin
                ctrl.busSrc  = mmcpu_pkg::MEM;
                ctrl.wrEn.dr = 1'b1;
            end
            mmcpu_pkg::ST_COPY: begin
                ctrl.busSrc  = mmcpu_pkg::DR;
                ctrl.wrEn.m1 = (sub == 4'd0);
                ctrl.wrEn.k1 = (sub == 4'd1);
                ctrl.wrEn.n1 = (sub == 4'd2);
            end
            mmcpu_pkg::ST_LOAD: begin
                ctrl.busSrc  = (sub == 4'd0) ? mmcpu_pkg::C1 : mmcpu_pkg::C2;
                ctrl.wrEn.ar = 1'b1;
            end
            mmcpu_pkg::ST_STORE1: begin
                ctrl.busSrc  = mmcpu_pkg::RT;
                ctrl.wrEn.dr = 1'b1;
            end
            mmcpu_pkg::ST_STORE2: begin
                ctrl.busSrc  = mmcpu_pkg::C3;
                ctrl.wrEn.ar = 1'b1;
            end
            mmcpu_pkg::ST_STORE3: dataOp = mmcpu_pkg::BUS_WRITE; // AR and DR go out
            mmcpu_pkg::ST_ASSIGN: begin
                ctrl.busSrc  = mmcpu_pkg::AR;
                ctrl.wrEn.c1 = (sub == 4'd0);
                ctrl.wrEn.c2 = (sub == 4'd1);
                ctrl.wrEn.c3 = (sub == 4'd2);
            end
            mmcpu_pkg::ST_RESET: begin
                ctrl.clrEn.rt = (sub == 4'd0);
                ctrl.clrEn.m2 = (sub == 4'd0);
                ctrl.clrEn.ac = (sub == 4'd0);
                ctrl.clrEn.n2 = (sub == 4'd0) || (sub == 4'd1);
                ctrl.clrEn.k2 = (sub == 4'd0) || (sub == 4'd2);
            end
            mmcpu_pkg::ST_MOVE: begin
                ctrl.busSrc  = mmcpu_pkg::AC;
                ctrl.wrEn.rp = (sub == 4'd0);
                ctrl.wrEn.rt = (sub == 4'd1);
                ctrl.wrEn.c1 = (sub == 4'd2);
            end
            mmcpu_pkg::ST_SET: begin
                ctrl.busSrc  = (sub == 4'd0) ? mmcpu_pkg::C1 : mmcpu_pkg::DR;
                ctrl.aluOp   = mmcpu_pkg::ALU_SET;
                ctrl.wrEn.ac = 1'b1;
            end
            mmcpu_pkg::ST_MUL: begin
                ctrl.busSrc  = mmcpu_pkg::RP;
                ctrl.aluOp   = mmcpu_pkg::ALU_MUL;
                ctrl.wrEn.ac = 1'b1;
            end
            mmcpu_pkg::ST_ADD: begin
                if (sub == 4'd0) begin
                    ctrl.busSrc = mmcpu_pkg::RT;
                end else if (sub == 4'd1) begin
                    ctrl.busSrc = mmcpu_pkg::M1;
                end else begin
                    ctrl.busSrc = mmcpu_pkg::M2;
                end
                ctrl.aluOp   = mmcpu_pkg::ALU_ADD;
                ctrl.wrEn.ac = 1'b1;
            end
            mmcpu_pkg::ST_INC: begin
                ctrl.incEn.c2 = (sub == 4'd0);
                ctrl.incEn.c3 = (sub == 4'd1);
                ctrl.incEn.m2 = (sub == 4'd2);
                ctrl.incEn.k2 = (sub == 4'd3);
                ctrl.incEn.n2 = (sub == 4'd4);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mmcpu_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_regfile (
    input  logic                         Clk,
    input  logic                         rst,
    input  mmcpu_pkg::ctrlT              ctrl,
    input  logic [`MMCPU_DATA_WIDTH-1:0] instrData,
    input  logic [`MMCPU_DATA_WIDTH-1:0] memData,
    input  logic [`MMCPU_DATA_WIDTH-1:0] aluResult,
    output logic [`MMCPU_DATA_WIDTH-1:0] ir,
    output logic [`MMCPU_ADDR_WIDTH-1:0] pc,
    output logic [`MMCPU_ADDR_WIDTH-1:0] ar,
    output logic [`MMCPU_DATA_WIDTH-1:0] dr,
    output logic [`MMCPU_DATA_WIDTH-1:0] acc,
    output logic [`MMCPU_DATA_WIDTH-1:0] busValue,
    output logic [`MMCPU_DATA_WIDTH-1:0] cmpA,
    output logic [`MMCPU_DATA_WIDTH-1:0] cmpB
);

    typedef logic [`MMCPU_DATA_WIDTH-1:0] wordT;

    // Field order follows regMaskT
    typedef struct packed {
        wordT pc, ir, ar, dr;
        wordT rp, rt, m1, k1;
        wordT n1, m2, k2, n2;
        wordT c1, c2, c3, ac;
    } regFileT;

    regFileT regs;

    // Clear beats increment, increment beats write
    function automatic wordT nextVal(input logic clr, input logic inc, input logic wr,
                                     input wordT cur, input wordT din);
        if (clr) begin
            return '0;
        end else if (inc) begin
            return cur + 1'b1;
        end else if (wr) begin
            return din;
        end
        return cur;
    endfunction

    always_ff @(posedge Clk) begin
        if (rst) begin
            regs <= '0;
        end else begin
            regs.pc <= nextVal(ctrl.clrEn.pc, ctrl.incEn.pc, ctrl.wrEn.pc, regs.pc, busValue);
            regs.ir <= nextVal(ctrl.clrEn.ir, ctrl.incEn.ir, ctrl.wrEn.ir, regs.ir, busValue);
            regs.ar <= nextVal(ctrl.clrEn.ar, ctrl.incEn.ar, ctrl.wrEn.ar, regs.ar, busValue);
            regs.dr <= nextVal(ctrl.clrEn.dr, ctrl.incEn.dr, ctrl.wrEn.dr, regs.dr, busValue);
            regs.rp <= nextVal(ctrl.clrEn.rp, ctrl.incEn.rp, ctrl.wrEn.rp, regs.rp, busValue);
            regs.rt <= nextVal(ctrl.clrEn.rt, ctrl.incEn.rt, ctrl.wrEn.rt, regs.rt, busValue);
            regs.m1 <= nextVal(ctrl.clrEn.m1, ctrl.incEn.m1, ctrl.wrEn.m1, regs.m1, busValue);
            regs.k1 <= nextVal(ctrl.clrEn.k1, ctrl.incEn.k1, ctrl.wrEn.k1, regs.k1, busValue);
            regs.n1 <= nextVal(ctrl.clrEn.n1, ctrl.incEn.n1, ctrl.wrEn.n1, regs.n1, busValue);
            regs.m2 <= nextVal(ctrl.clrEn.m2, ctrl.incEn.m2, ctrl.wrEn.m2, regs.m2, busValue);
            regs.k2 <= nextVal(ctrl.clrEn.k2, ctrl.incEn.k2, ctrl.wrEn.k2, regs.k2, busValue);
            regs.n2 <= nextVal(ctrl.clrEn.n2, ctrl.incEn.n2, ctrl.wrEn.n2, regs.n2, busValue);
            regs.c1 <= nextVal(ctrl.clrEn.c1, ctrl.incEn.c1, ctrl.wrEn.c1, regs.c1, busValue);
            regs.c2 <= nextVal(ctrl.clrEn.c2, ctrl.incEn.c2, ctrl.wrEn.c2, regs.c2, busValue);
            regs.c3 <= nextVal(ctrl.clrEn.c3, ctrl.incEn.c3, ctrl.wrEn.c3, regs.c3, busValue);
            regs.ac <= nextVal(ctrl.clrEn.ac, ctrl.incEn.ac, ctrl.wrEn.ac, regs.ac, aluResult);
        end
    end

    // Internal bus source
    always_comb begin
        case (ctrl.busSrc)
            mmcpu_pkg::MEM:   busValue = memData;
            mmcpu_pkg::INSTR: busValue = instrData;
            mmcpu_pkg::AR:    busValue = regs.ar;
            mmcpu_pkg::DR:    busValue = regs.dr;
            mmcpu_pkg::RP:    busValue = regs.rp;
            mmcpu_pkg::RT:    busValue = regs.rt;
            mmcpu_pkg::M1:    busValue = regs.m1;
            mmcpu_pkg::M2:    busValue = regs.m2;
            mmcpu_pkg::C1:    busValue = regs.c1;
            mmcpu_pkg::C2:    busValue = regs.c2;
            mmcpu_pkg::C3:    busValue = regs.c3;
            mmcpu_pkg::AC:    busValue = regs.ac;
            default:          busValue = '0;
        endcase
    end

    // Loop bound against loop index
    always_comb begin
        case (ctrl.cmpSel)
            mmcpu_pkg::CMP_K: begin
                cmpA = regs.k1;
                cmpB = regs.k2;
            end
            mmcpu_pkg::CMP_N: begin
                cmpA = regs.n1;
                cmpB = regs.n2;
            end
            default: begin
                cmpA = regs.m1;
                cmpB = regs.m2;
            end
        endcase
    end

    assign ir  = regs.ir;
    assign pc  = regs.pc;
    assign ar  = regs.ar;
    assign dr  = regs.dr;
    assign acc = regs.ac;

endmodule

`default_nettype wire

// ==== logic/mmcpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_top (
    input  logic              Clk,
    input  logic              rst,
    output mmcpu_pkg::wbReqT  instrReq,
    input  mmcpu_pkg::wbRspT  instrRsp,
    output mmcpu_pkg::wbReqT  dataReq,
    input  mmcpu_pkg::wbRspT  dataRsp,
    output logic              halted
);

    mmcpu_pkg::ctrlT              ctrl;
    mmcpu_pkg::busOpT             instrOp;
    mmcpu_pkg::busOpT             dataOp;
    logic                         z;
    logic                         instrDone;
    logic                         dataDone;
    logic [`MMCPU_DATA_WIDTH-1:0] ir;
    logic [`MMCPU_ADDR_WIDTH-1:0] pc;
    logic [`MMCPU_ADDR_WIDTH-1:0] ar;
    logic [`MMCPU_DATA_WIDTH-1:0] dr;
    logic [`MMCPU_DATA_WIDTH-1:0] acc;
    logic [`MMCPU_DATA_WIDTH-1:0] busValue;
    logic [`MMCPU_DATA_WIDTH-1:0] cmpA;
    logic [`MMCPU_DATA_WIDTH-1:0] cmpB;
    logic [`MMCPU_DATA_WIDTH-1:0] aluResult;
    logic [`MMCPU_DATA_WIDTH-1:0] instrData;
    logic [`MMCPU_DATA_WIDTH-1:0] memData;

    // Port names match the local wires
    mmcpu_control controlInst (.*);
    mmcpu_regfile regfileInst (.*);
    mmcpu_alu     aluInst     (.*);

    // Instruction ROM side, read only
    mmcpu_busport instrPort (
        .Clk    (Clk),
        .rst    (rst),
        .op     (instrOp),
        .adr    (pc),
        .wrData ('0),
        .req    (instrReq),
        .rsp    (instrRsp),
        .rdData (instrData),
        .done   (instrDone)
    );

    mmcpu_busport dataPort (
        .Clk    (Clk),
        .rst    (rst),
        .op     (dataOp),
        .adr    (ar),
        .wrData (dr),
        .req    (dataReq),
        .rsp    (dataRsp),
        .rdData (memData),
        .done   (dataDone)
    );

endmodule

`default_nettype wire

// ==== testbench/mmcpu_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free-running clock for the testbench
module mmcpu_clkgen #(
    parameter int periodNs = 40
) (
    output logic Clk
);

    initial begin
        Clk = 1'b0;
        forever #(periodNs / 2) Clk = ~Clk;
    end

endmodule

`default_nettype wire

// ==== testbench/mmcpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mmcpu_defines.svh"

module mmcpu_tb;

    localparam int MaxAckDelay = 3;

    typedef logic [`MMCPU_DATA_WIDTH-1:0] byteT;

    logic             Clk;
    logic             rst;
    mmcpu_pkg::wbReqT instrReq;
    mmcpu_pkg::wbReqT dataReq;
    mmcpu_pkg::wbRspT instrRsp;
    mmcpu_pkg::wbRspT dataRsp;
    logic             halted;

    byteT romMem [0:255];
    byteT dataMem [0:255];
    byteT expAdr [$];
    byteT expDat [$];
    int   numI;
    int   numD;
    int   numE;
    int   cycleCount;
    int   cycleLimit;

    // Per-port handshake tracking
    logic             instrActive;
    logic             dataActive;
    int               instrWait;
    int               dataWait;
    mmcpu_pkg::wbReqT instrHeld;
    mmcpu_pkg::wbReqT dataHeld;

    // Program flow tracking
    byteT expPc;
    logic operandNext;  // Next ROM read is an operand word
    logic jmpOperand;
    logic haltSeen;
    int   copyTarget;   // -1 when no COPY waits for its data read
    byteT copyAdr;
    byteT bound [3];    // M1, K1, N1
    byteT idx [3];      // M2, K2, N2

    mmcpu_clkgen #(.periodNs(40)) clkInst (.Clk(Clk));

    mmcpu_top mmcpu_top_inst (
        .Clk      (Clk),
        .rst      (rst),
        .instrReq (instrReq),
        .instrRsp (instrRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp),
        .halted   (halted)
    );

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkReq(input string name, input mmcpu_pkg::wbReqT exp,
                            input mmcpu_pkg::wbReqT act);
        if (act !== exp) begin
            stopRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkByte(input string name, input byteT exp, input byteT act);
        if (act !== exp) begin
            stopRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stopRun($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic loadVectors;
        int                 fd;
        int                 n;
        int                 fields;
        logic [8*96-1:0]    lineBuf;
        logic [7:0]         kind;
        logic [31:0]        a;
        logic [31:0]        v;
        for (int i = 0; i < 256; i++) begin
            romMem[i]  = byteT'(i) ^ 8'hC3;
            dataMem[i] = byteT'(i) ^ 8'h5A;
        end
        fd = $fopen("testbench/mmcpu_vectors.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the vectors file");
        end
        while (!$feof(fd)) begin
            lineBuf = '0;
            n = $fgets(lineBuf, fd);
            if (n > 0) begin
                fields = $sscanf(lineBuf, "%s %h %h", kind, a, v); // Comment lines fail here
                if (fields == 3 && kind == "I") begin
                    romMem[a[7:0]] = v[7:0];
                    numI++;
                end else if (fields == 3 && kind == "D") begin
                    dataMem[a[7:0]] = v[7:0];
                    numD++;
                end else if (fields == 3 && kind == "E") begin
                    expAdr.push_back(a[7:0]);
                    expDat.push_back(v[7:0]);
                    numE++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Predicts the next ROM address and mirrors the loop indices
    task automatic followFetch(input byteT adr);
        byteT              word;
        mmcpu_pkg::opcodeT op;
        logic [3:0]        sub;
        word  = romMem[adr];
        op    = mmcpu_pkg::opcodeT'(word[7:4]);
        sub   = word[3:0];
        expPc = adr + 8'd1;
        if (operandNext) begin
            operandNext = 1'b0;
            if (jmpOperand) begin
                expPc = word;
            end
            if (copyTarget >= 0) begin
                copyAdr = word; // Data address of the pending COPY
            end
            jmpOperand = 1'b0;
        end else begin
            case (op)
                mmcpu_pkg::JMP: begin
                    if (bound[sub[1:0]] != idx[sub[1:0]]) begin
                        operandNext = 1'b1;
                        jmpOperand  = 1'b1;
                    end else begin
                        expPc = adr + 8'd2; // Equal pair skips the target
                    end
                end
                mmcpu_pkg::COPY: begin
                    operandNext = 1'b1;
                    copyTarget  = sub;
                end
                mmcpu_pkg::ASSIGN: operandNext = 1'b1;
                mmcpu_pkg::RESET: begin
                    if (sub == 4'd0) begin
                        idx[0] = '0;
                        idx[1] = '0;
                        idx[2] = '0;
                    end else if (sub == 4'd1) begin
                        idx[2] = '0;
                    end else if (sub == 4'd2) begin
                        idx[1] = '0;
                    end
                end
                mmcpu_pkg::INC: begin
                    if (sub >= 4'd2 && sub <= 4'd4) begin
                        idx[sub - 4'd2] = idx[sub - 4'd2] + 8'd1;
                    end
                end
                mmcpu_pkg::HALT: haltSeen = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic serviceInstr;
        if (instrRsp.ack) begin
            checkBit("instruction cyc after ack", 1'b0, instrReq.cyc);
            instrRsp.ack = 1'b0;
            instrActive  = 1'b0;
        end else if (instrReq.cyc || instrReq.stb) begin
            if (!instrActive) begin
                if (haltSeen) begin
                    stopRun("instruction bus cycle started after HALT");
                end
                checkByte("fetch address", expPc, instrReq.adr);
                checkBit("instruction write enable", 1'b0, instrReq.we);
                instrHeld   = instrReq;
                instrActive = 1'b1;
                instrWait   = $urandom % (MaxAckDelay + 1);
                followFetch(instrReq.adr);
            end else begin
                checkReq("instruction request held", instrHeld, instrReq);
            end
            if (instrWait == 0) begin
                instrRsp.datR = romMem[instrReq.adr];
                instrRsp.ack  = 1'b1;
            end else begin
                instrWait--;
            end
        end
    endtask

    task automatic recordStore(input byteT adr, input byteT dat);
        byteT a;
        byteT d;
        if (expAdr.size() == 0) begin
            stopRun("data write seen with no expected store left");
        end
        a = expAdr.pop_front();
        d = expDat.pop_front();
        checkByte("store address", a, adr);
        checkByte("store data", d, dat);
        dataMem[adr] = dat;
    endtask

    task automatic serviceData;
        if (dataRsp.ack) begin
            checkBit("data cyc after ack", 1'b0, dataReq.cyc);
            dataRsp.ack = 1'b0;
            dataActive  = 1'b0;
        end else if (dataReq.cyc || dataReq.stb) begin
            if (!dataActive) begin
                if (haltSeen) begin
                    stopRun("data bus cycle started after HALT");
                end
                dataHeld   = dataReq;
                dataActive = 1'b1;
                dataWait   = $urandom % (MaxAckDelay + 1);
            end else begin
                checkReq("data request held", dataHeld, dataReq);
            end
            if (dataWait == 0) begin
                if (dataReq.we) begin
                    recordStore(dataReq.adr, dataReq.datW);
                end else begin
                    dataRsp.datR = dataMem[dataReq.adr];
                    if (copyTarget >= 0) begin
                        checkByte("copy read address", copyAdr, dataReq.adr);
                        bound[copyTarget] = dataMem[copyAdr]; // COPY loads a bound
                        copyTarget = -1;
                    end
                end
                dataRsp.ack = 1'b1;
            end else begin
                dataWait--;
            end
        end
    endtask

    // Memory models answer on the falling edge
    initial begin
        int seedInit;
        seedInit = $urandom(5);
        forever begin
            @(negedge Clk);
            if (!rst) begin
                if (!haltSeen) begin
                    checkBit("halted before HALT", 1'b0, halted);
                end
                serviceInstr();
                serviceData();
            end
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            stopRun($sformatf("timeout, no HALT after %0d cycles", cycleCount));
        end
    end

    initial begin
        rst         = 1'b1;
        instrRsp    = '0;
        dataRsp     = '0;
        instrActive = 1'b0;
        dataActive  = 1'b0;
        instrWait   = 0;
        dataWait    = 0;
        expPc       = '0;
        operandNext = 1'b0;
        jmpOperand  = 1'b0;
        haltSeen    = 1'b0;
        copyTarget  = -1;
        copyAdr     = '0;
        for (int i = 0; i < 3; i++) begin
            bound[i] = '0;
            idx[i]   = '0;
        end
        numI        = 0;
        numD        = 0;
        numE        = 0;
        cycleCount  = 0;
        loadVectors();
        // Each ROM word is fetched at most about four times by the two loops
        cycleLimit = 40 * numI + MaxAckDelay * (4 * numI + 4 * numD + numE);
        repeat (5) begin
            @(negedge Clk);
            checkReq("instruction bus in reset", mmcpu_pkg::wbReqT'('0), instrReq);
            checkReq("data bus in reset", mmcpu_pkg::wbReqT'('0), dataReq);
            checkBit("halted in reset", 1'b0, halted);
        end
        rst = 1'b0;
        while (!halted) begin
            @(negedge Clk);
        end
        repeat (20) @(negedge Clk); // Quiet buses after HALT
        checkBit("halted held", 1'b1, halted);
        if (expAdr.size() != 0) begin
            stopRun($sformatf("%0d expected stores never happened", expAdr.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mmcpu_vectors.txt ====
# kind addr value: I = ROM word, D = initial data word, E = expected store
# A row-major at 10, B column-major at 20, 2x2 result from 30
I 00 52
I 01 30
I 02 20
I 03 00
I 04 22
I 05 00
I 06 51
I 07 20
I 08 50
I 09 10
I 0A 80
I 0B A2
I 0C A2
I 0D 72
I 0E 30
I 0F 81
I 10 70
I 11 31
I 12 81
I 13 90
I 14 71
I 15 B0
I 16 50
I 17 11
I 18 80
I 19 A2
I 1A A2
I 1B 72
I 1C 30
I 1D 81
I 1E 70
I 1F 31
I 20 81
I 21 90
I 22 A0
I 23 71
I 24 B0
I 25 40
I 26 B1
I 27 B4
I 28 12
I 29 08
I 2A 61
I 2B B2
I 2C 10
I 2D 06
I 2E F0
D 00 02
D 10 03
D 11 05
D 12 07
D 13 C8
D 20 0B
D 21 11
D 22 0D
D 23 13
E 30 76
E 31 86
E 32 95
E 33 33

// ==== src.f ====
+incdir+include
logic/mmcpu_pkg.sv
logic/mmcpu_alu.sv
logic/mmcpu_busport.sv
logic/mmcpu_control.sv
logic/mmcpu_regfile.sv
logic/mmcpu_top.sv
testbench/mmcpu_clkgen.sv
testbench/mmcpu_tb.sv

// ==== Bender.yml ====
package:
  name: mmcpu

sources:
  - include_dirs:
      - include
    files:
      - logic/mmcpu_pkg.sv
      - logic/mmcpu_alu.sv
      - logic/mmcpu_busport.sv
      - logic/mmcpu_control.sv
      - logic/mmcpu_regfile.sv
      - logic/mmcpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mmcpu_clkgen.sv
      - testbench/mmcpu_tb.sv
